//--- hdl/led_blink_top.sv
module led_blink_top
#(
   // count bit that sets the blink rate
   parameter int TAP           = 23,
   // length of the freeze window per swap
   parameter int FREEZE_CYCLES = 16
)
(
   ////////////////////
   // clock and reset
   ////////////////////
   input  logic                  clock,
   input  logic                  rst,

   ////////////////////
   // swap request
   ////////////////////
   // one-cycle strobe
   input  logic                  load,
   // sampled with load
   input  led_pkg::persona_t     persona_sel,

   ////////////////////
   // LEDs
   ////////////////////
   output logic                  led_zero_on,
   output logic                  led_one_on,
   output logic                  led_two_on,
   output logic                  led_three_on,

   ////////////////////
   // swap status
   ////////////////////
   output logic                  freeze,
   output led_pkg::load_status_t status
);

   import led_pkg::*;

   // shared time base
   logic [COUNT_WIDTH-1:0] count;
   // persona currently driving the swappable region
   persona_t               active_persona;
   // raw pattern bits before the freeze override
   logic                   persona_two;
   logic                   persona_three;

   ////////////////////
   // static region
   ////////////////////

   pulse_counter u_pulse_counter
   (
      .clock          (clock),
      .rst            (rst),
      .count          (count)
   );

   ////////////////////
   // swappable region
   ////////////////////

   led_persona #(
      .TAP            (TAP)
   ) u_led_persona
   (
      .clock          (clock),
      .rst            (rst),
      .count          (count),
      .active_persona (active_persona),
      .persona_two    (persona_two),
      .persona_three  (persona_three)
   );

   ////////////////////
   // loader and output stage
   ////////////////////

   persona_loader #(
      .TAP            (TAP),
      .FREEZE_CYCLES  (FREEZE_CYCLES)
   ) u_persona_loader
   (
      .clock          (clock),
      .rst            (rst),
      .load           (load),
      .persona_sel    (persona_sel),
      .count          (count),
      .persona_two    (persona_two),
      .persona_three  (persona_three),
      .active_persona (active_persona),
      .freeze         (freeze),
      .status         (status),
      .led_zero_on    (led_zero_on),
      .led_one_on     (led_one_on),
      .led_two_on     (led_two_on),
      .led_three_on   (led_three_on)
   );

endmodule

//--- hdl/led_persona.sv
module led_persona
#(
   // count bit that sets the blink rate
   parameter int TAP = 23
)
(
   ////////////////////
   // clock and reset
   ////////////////////
   input  logic                           clock,
   input  logic                           rst,

   ////////////////////
   // pattern inputs
   ////////////////////
   input  logic [led_pkg::COUNT_WIDTH-1:0] count,
   input  led_pkg::persona_t              active_persona,

   ////////////////////
   // pattern outputs
   ////////////////////
   output logic                           persona_two,
   output logic                           persona_three
);

   import led_pkg::*;

   // slow bit and the next slower bit of the count
   logic tap_bit;
   logic rate_bit;

   assign tap_bit  = count[TAP];
   assign rate_bit = count[TAP+1];

   ////////////////////
   // pattern decode
   ////////////////////

   // one register stage, outputs in cycle n+1 follow count of cycle n
   // freeze is not seen here, the loader does the override
   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         persona_two   <= 1'b0;
         persona_three <= 1'b0;
      end
      else
      begin
         case (active_persona)
            PERSONA_BLINK:
            begin
               persona_two   <= tap_bit;
               persona_three <= tap_bit;
            end
            PERSONA_ALTERNATE:
            begin
               // opposite phase
               persona_two   <= tap_bit;
               persona_three <= ~tap_bit;
            end
            PERSONA_BINARY:
            begin
               // led two is the msb of the pair
               persona_two   <= rate_bit;
               persona_three <= tap_bit;
            end
            PERSONA_DARK:
            begin
               persona_two   <= 1'b0;
               persona_three <= 1'b0;
            end
            default:
            begin
               persona_two   <= 1'b0;
               persona_three <= 1'b0;
            end
         endcase
      end
   end

endmodule

//--- hdl/led_pkg.sv
package led_pkg;

   ////////////////////
   // time base
   ////////////////////

   // width of the free-running count register
   localparam int COUNT_WIDTH = 32;

   ////////////////////
   // persona opcodes
   ////////////////////

   // each opcode selects one LED pattern for the swappable region
   typedef enum logic [1:0] {
      // both LEDs blink together on the tap bit
      PERSONA_BLINK     = 2'd0,
      // LEDs blink in opposite phase
      PERSONA_ALTERNATE = 2'd1,
      // two-bit binary count taken from tap and tap+1
      PERSONA_BINARY    = 2'd2,
      // both LEDs held off
      PERSONA_DARK      = 2'd3
   } persona_t;

   ////////////////////
   // loader
   ////////////////////

   // swap sequencing states
   typedef enum logic [1:0] {
      LOADER_IDLE    = 2'd0,
      LOADER_FREEZE  = 2'd1,
      LOADER_RELEASE = 2'd2
   } loader_state_t;

   // status levels seen outside the design
   typedef enum logic [1:0] {
      STATUS_IDLE  = 2'd0,
      STATUS_BUSY  = 2'd1,
      STATUS_DONE  = 2'd2,
      STATUS_ERROR = 2'd3
   } load_status_t;

endpackage

//--- hdl/persona_loader.sv
module persona_loader
#(
   // count bit that sets the blink rate
   parameter int TAP           = 23,
   // cycles the persona region is held frozen per swap
   parameter int FREEZE_CYCLES = 16
)
(
   input  logic                           clock,
   input  logic                           rst,
   // swap request
   input  logic                           load,
   input  led_pkg::persona_t              persona_sel,
   // static time base and persona results
   input  logic [led_pkg::COUNT_WIDTH-1:0] count,
   input  logic                           persona_two,
   input  logic                           persona_three,
   // persona region control
   output led_pkg::persona_t              active_persona,
   output logic                           freeze,
   output led_pkg::load_status_t          status,
   // merged LED outputs
   output logic                           led_zero_on,
   output logic                           led_one_on,
   output logic                           led_two_on,
   output logic                           led_three_on
);

   import led_pkg::*;

   // freeze length counter width, at least one bit
   localparam int CNT_W = (FREEZE_CYCLES > 1) ? $clog2(FREEZE_CYCLES) : 1;

   loader_state_t    state;
   logic [CNT_W-1:0] freeze_cnt;
   // requested persona, held until commit
   persona_t         pending_persona;
   persona_t         commit_persona;
   logic             accept;
   logic             reject;
   logic             last_freeze;
   logic             commit;
   // static bits delayed to line up with the persona register
   logic             static_zero_d;
   logic             static_one_d;

   ////////////////////
   // request decode
   ////////////////////

   // only an idle loader takes a new persona
   assign accept      = load && (state == LOADER_IDLE);
   // freeze or release still running, request is dropped
   assign reject      = load && (state != LOADER_IDLE);
   assign last_freeze = (state == LOADER_FREEZE) && (freeze_cnt == '0);

   // new persona shows on the final freeze cycle
   // with a single freeze cycle that is the cycle right after the load
   assign commit = (FREEZE_CYCLES == 1) ? accept :
                   ((state == LOADER_FREEZE) && (freeze_cnt == CNT_W'(1)));
   assign commit_persona = (FREEZE_CYCLES == 1) ? persona_sel : pending_persona;

   // capture the request on accept only
   always_ff @(posedge clock)
   begin
      if (accept)
      begin
         pending_persona <= persona_sel;
      end
   end

   ////////////////////
   // swap FSM
   ////////////////////

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         state          <= LOADER_IDLE;
         freeze_cnt     <= '0;
         freeze         <= 1'b0;
         status         <= STATUS_IDLE;
         active_persona <= PERSONA_BLINK;
      end
      else
      begin
         case (state)
            LOADER_IDLE:
            begin
               if (accept)
               begin
                  // freeze high from the next cycle on
                  state      <= LOADER_FREEZE;
                  freeze_cnt <= CNT_W'(FREEZE_CYCLES - 1);
                  freeze     <= 1'b1;
               end
            end
            LOADER_FREEZE:
            begin
               if (freeze_cnt == '0)
               begin
                  state  <= LOADER_RELEASE;
                  freeze <= 1'b0;
               end
               else
               begin
                  freeze_cnt <= freeze_cnt - CNT_W'(1);
               end
            end
            LOADER_RELEASE:
            begin
               // forced LEDs drain out of the output stage here
               state <= LOADER_IDLE;
            end
            default:
            begin
               state  <= LOADER_IDLE;
               freeze <= 1'b0;
            end
         endcase

         if (commit)
         begin
            active_persona <= commit_persona;
         end

         // error stays until the next accepted load
         if (accept)
         begin
            status <= STATUS_BUSY;
         end
         else if (reject)
         begin
            status <= STATUS_ERROR;
         end
         else if (last_freeze && (status != STATUS_ERROR))
         begin
            status <= STATUS_DONE;
         end
      end
   end

   ////////////////////
   // output stage
   ////////////////////

   // one stage of delay on the static taps
   always_ff @(posedge clock)
   begin
      static_zero_d <= count[TAP];
      static_one_d  <= count[TAP+1];
   end

   // all four LEDs registered together, persona pair forced on while frozen
   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         led_zero_on  <= 1'b0;
         led_one_on   <= 1'b0;
         led_two_on   <= 1'b0;
         led_three_on <= 1'b0;
      end
      else
      begin
         led_zero_on  <= static_zero_d;
         led_one_on   <= static_one_d;
         led_two_on   <= freeze | persona_two;
         led_three_on <= freeze | persona_three;
      end
   end

endmodule

//--- hdl/pulse_counter.sv
module pulse_counter
(
   ////////////////////
   // clock and reset
   ////////////////////
   input  logic                           clock,
   input  logic                           rst,

   ////////////////////
   // time base out
   ////////////////////
   // every LED in the design is derived from this register
   output logic [led_pkg::COUNT_WIDTH-1:0] count
);

   import led_pkg::*;

   ////////////////////
   // count register
   ////////////////////

   // free-running binary counter
   // holds zero while rst is high, so the first cycle after reset sees 0
   // wraps naturally at 2**COUNT_WIDTH
   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         // restart the time base
         count <= '0;
      end
      else
      begin
         // one step per clock, no enable
         count <= count + COUNT_WIDTH'(1);
      end
   end

   // the static LEDs tap this count through the loader output stage
   // the persona block taps the very same count value
   // so both regions stay phase locked across a swap

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the LED blinker testbench with Verilator and runs it
# the run passes only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

sim_output=$(
   {
      verilator --binary --timing --assert \
         --top-module led_blink_tb \
         --Mdir obj_dir \
         -o led_blink_sim \
         -f tb.f \
      && ./obj_dir/led_blink_sim
   } 2>&1
)

echo "${sim_output}"

echo "${sim_output}" | grep -qF "Simulation finished: PASS" \
   && { echo "run_sim: simulation passed"; exit 0; } \
   || { echo "run_sim: simulation failed"; exit 1; }

//--- tb.f
hdl/led_pkg.sv
hdl/pulse_counter.sv
hdl/led_persona.sv
hdl/persona_loader.sv
hdl/led_blink_top.sv
verification/led_blink_checker.sv
verification/led_blink_tb.sv

//--- verification/led_blink_checker.sv
module led_blink_checker
#(
   // length of one swap freeze window
   parameter int FREEZE_CYCLES = 16
)
(
   input  logic                          clock,
   input  logic                          rst,
   input  led_pkg::loader_state_t        state,
   input  logic                          freeze,
   input  led_pkg::load_status_t         status,
   input  logic                          led_zero_on,
   input  logic                          led_one_on,
   input  logic                          led_two_on,
   input  logic                          led_three_on
);

   import led_pkg::*;

   // freeze-high cycles seen before the current one
   int freeze_run;

   always_ff @(posedge clock)
   begin
      if (rst || !freeze)
      begin
         freeze_run <= 0;
      end
      else
      begin
         freeze_run <= freeze_run + 1;
      end
   end

   ////////////////////
   // freeze window
   ////////////////////

   // a run of freeze never grows past the window length
   freeze_length_limit: assert property (@(posedge clock) disable iff (rst)
      !(freeze && (freeze_run >= FREEZE_CYCLES)))
      else $error("freeze held for more than %0d cycles", FREEZE_CYCLES);

   // registered freeze forces the persona pair on one cycle later
   freeze_forces_leds: assert property (@(posedge clock) disable iff (rst)
      freeze |=> (led_two_on && led_three_on))
      else $error("persona LEDs not forced on after freeze");

   ////////////////////
   // reset values
   ////////////////////

   reset_values: assert property (@(posedge clock)
      rst |=> (!led_zero_on && !led_one_on && !led_two_on && !led_three_on
               && !freeze && (status == STATUS_IDLE) && (state == LOADER_IDLE)))
      else $error("outputs not at reset values after rst");

endmodule

bind persona_loader led_blink_checker #(
   .FREEZE_CYCLES (FREEZE_CYCLES)
) u_led_blink_checker
(
   .clock         (clock),
   .rst           (rst),
   .state         (state),
   .freeze        (freeze),
   .status        (status),
   .led_zero_on   (led_zero_on),
   .led_one_on    (led_one_on),
   .led_two_on    (led_two_on),
   .led_three_on  (led_three_on)
);

//--- verification/led_blink_tb.sv
module led_blink_tb;

   import led_pkg::*;

   localparam int          TAP           = 3;
   localparam int          FREEZE_CYCLES = 6;
   localparam logic [31:0] SEED          = 32'hb85a110c;
   localparam int          RANDOM_LOADS  = 24;
   localparam int          MAX_GAP       = 12;
   // cycles per test in run order, timeout is twice the sum
   localparam int TEST_CYCLES = 10 + 64 + 60 + 90 + 50 + RANDOM_LOADS * (MAX_GAP + 1) + 20;
   localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

   logic         clock;
   logic         rst;
   logic         load;
   persona_t     persona_sel;
   logic         led_zero_on;
   logic         led_one_on;
   logic         led_two_on;
   logic         led_three_on;
   logic         freeze;
   load_status_t status;

   int          error_count;
   int          test_base;
   int          tests_run;
   int          tests_failed;
   int          cycle_count;
   logic [31:0] seed_word;

   ////////////////////
   // reference model state, values of the current cycle
   ////////////////////
   int                     m_cycle;
   logic [COUNT_WIDTH-1:0] m_count;
   logic [COUNT_WIDTH-1:0] m_count_d1;
   logic [COUNT_WIDTH-1:0] m_count_d2;
   persona_t               m_active;
   persona_t               m_active_d1;
   persona_t               m_pending;
   logic                   m_freeze;
   load_status_t           m_status;
   logic                   m_led_zero;
   logic                   m_led_one;
   logic                   m_led_two;
   logic                   m_led_three;
   logic                   m_swap_valid;
   int                     m_swap_start;
   int                     m_accepted;
   int                     m_rejected;

   led_blink_top #(
      .TAP           (TAP),
      .FREEZE_CYCLES (FREEZE_CYCLES)
   ) uut
   (
      .clock         (clock),
      .rst           (rst),
      .load          (load),
      .persona_sel   (persona_sel),
      .led_zero_on   (led_zero_on),
      .led_one_on    (led_one_on),
      .led_two_on    (led_two_on),
      .led_three_on  (led_three_on),
      .freeze        (freeze),
      .status        (status)
   );

   // period 10, first rising edge at 5
   always
   begin
      clock = 1'b0;
      #5;
      clock = 1'b1;
      #5;
   end

   // persona pattern {led two, led three} for one count value
   function automatic logic [1:0] expected_pattern(input persona_t p,
                                                  input logic [COUNT_WIDTH-1:0] c);
      case (p)
         PERSONA_BLINK:     expected_pattern = {c[TAP], c[TAP]};
         PERSONA_ALTERNATE: expected_pattern = {c[TAP], ~c[TAP]};
         PERSONA_BINARY:    expected_pattern = {c[TAP+1], c[TAP]};
         // dark
         default:           expected_pattern = 2'b00;
      endcase
   endfunction

   // a swap runs from its load through the last forced LED cycle
   function automatic logic swap_in_progress(input int c);
      swap_in_progress = m_swap_valid && (c >= m_swap_start)
                         && (c <= m_swap_start + FREEZE_CYCLES + 1);
   endfunction

   ////////////////////
   // model update
   ////////////////////

   // inputs read here are the values the DUT samples on this edge
   always @(posedge clock)
   begin
      logic [1:0]   pat;
      load_status_t next_status;
      if (rst)
      begin
         m_cycle      = 0;
         m_count      = '0;
         m_count_d1   = '0;
         m_count_d2   = '0;
         m_active     = PERSONA_BLINK;
         m_active_d1  = PERSONA_BLINK;
         m_pending    = PERSONA_BLINK;
         m_freeze     = 1'b0;
         m_status     = STATUS_IDLE;
         m_led_zero   = 1'b0;
         m_led_one    = 1'b0;
         m_led_two    = 1'b0;
         m_led_three  = 1'b0;
         m_swap_valid = 1'b0;
         m_swap_start = 0;
         m_accepted   = 0;
         m_rejected   = 0;
      end
      else
      begin
         // LEDs next cycle show count of the cycle before this one
         pat         = expected_pattern(m_active_d1, m_count_d1);
         m_led_zero  = m_count_d1[TAP];
         m_led_one   = m_count_d1[TAP+1];
         m_led_two   = m_freeze | pat[1];
         m_led_three = m_freeze | pat[0];
         // load handling for the cycle that ends now
         next_status = m_status;
         if (load && swap_in_progress(m_cycle))
         begin
            next_status = STATUS_ERROR;
            m_rejected++;
         end
         else if (load)
         begin
            m_swap_valid = 1'b1;
            m_swap_start = m_cycle;
            m_pending    = persona_sel;
            next_status  = STATUS_BUSY;
            m_accepted++;
         end
         else if (m_swap_valid && (m_cycle == m_swap_start + FREEZE_CYCLES)
                  && (m_status != STATUS_ERROR))
         begin
            next_status = STATUS_DONE;
         end
         m_count_d2  = m_count_d1;
         m_count_d1  = m_count;
         m_count     = m_count + 1;
         m_active_d1 = m_active;
         m_cycle++;
         // freeze window k+1 .. k+FREEZE_CYCLES, persona commits on its last cycle
         m_freeze = m_swap_valid && (m_cycle > m_swap_start)
                    && (m_cycle <= m_swap_start + FREEZE_CYCLES);
         if (m_swap_valid && (m_cycle == m_swap_start + FREEZE_CYCLES))
         begin
            m_active = m_pending;
         end
         m_status = next_status;
      end
   end

   ////////////////////
   // helpers
   ////////////////////

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
         error_count++;
      end
   endtask

   task automatic check_outputs();
      compare_value("led_zero_on", 32'(m_led_zero), 32'(led_zero_on));
      compare_value("led_one_on", 32'(m_led_one), 32'(led_one_on));
      compare_value("led_two_on", 32'(m_led_two), 32'(led_two_on));
      compare_value("led_three_on", 32'(m_led_three), 32'(led_three_on));
      compare_value("freeze", 32'(m_freeze), 32'(freeze));
      compare_value("status", 32'(m_status), 32'(status));
   endtask

   task automatic check_reset_values();
      compare_value("led_zero_on", 32'(1'b0), 32'(led_zero_on));
      compare_value("led_one_on", 32'(1'b0), 32'(led_one_on));
      compare_value("led_two_on", 32'(1'b0), 32'(led_two_on));
      compare_value("led_three_on", 32'(1'b0), 32'(led_three_on));
      compare_value("freeze", 32'(1'b0), 32'(freeze));
      compare_value("status", 32'(STATUS_IDLE), 32'(status));
   endtask

   // one clock with load low, outputs checked at the falling edge
   task automatic step();
      @(posedge clock);
      load <= 1'b0;
      @(negedge clock);
      check_outputs();
   endtask

   // load strobe for one cycle
   task automatic drive_load(input persona_t p);
      @(posedge clock);
      load        <= 1'b1;
      persona_sel <= p;
      @(negedge clock);
      check_outputs();
   endtask

   // steps until freeze drops, counting the high cycles left
   task automatic wait_freeze_end(input logic check_busy, output int len);
      int   guard;
      logic freeze_prev;
      len         = 0;
      guard       = 0;
      freeze_prev = freeze;
      step();
      while ((freeze === 1'b1) && (guard < 4 * FREEZE_CYCLES))
      begin
         len++;
         if (check_busy)
         begin
            compare_value("status", 32'(STATUS_BUSY), 32'(status));
         end
         if (freeze_prev)
         begin
            compare_value("led_two_on", 32'(1'b1), 32'(led_two_on));
            compare_value("led_three_on", 32'(1'b1), 32'(led_three_on));
         end
         freeze_prev = freeze;
         step();
         guard++;
      end
      if (guard >= 4 * FREEZE_CYCLES)
      begin
         $display("freeze still high after %0d cycles at t=%0t", guard, $time);
         error_count++;
      end
      // last forced cycle trails the window by one
      if (freeze_prev)
      begin
         compare_value("led_two_on", 32'(1'b1), 32'(led_two_on));
         compare_value("led_three_on", 32'(1'b1), 32'(led_three_on));
      end
   endtask

   // all four LEDs against count two cycles back and a fixed persona
   task automatic check_pattern_window(input persona_t p, input int cycles);
      logic [1:0] pat;
      repeat (cycles)
      begin
         step();
         pat = expected_pattern(p, m_count_d2);
         compare_value("led_zero_on", 32'(m_count_d2[TAP]), 32'(led_zero_on));
         compare_value("led_one_on", 32'(m_count_d2[TAP+1]), 32'(led_one_on));
         compare_value("led_two_on", 32'(pat[1]), 32'(led_two_on));
         compare_value("led_three_on", 32'(pat[0]), 32'(led_three_on));
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (error_count == test_base)
      begin
         $display("[test] %s: ok", name);
      end
      else
      begin
         tests_failed++;
         $display("[test] %s: %0d mismatches", name, error_count - test_base);
      end
   endtask

   ////////////////////
   // tests
   ////////////////////

   task automatic test_reset();
      test_base = error_count;
      repeat (8)
      begin
         @(posedge clock);
         @(negedge clock);
         check_reset_values();
      end
      @(posedge clock);
      rst <= 1'b0;
      // cycle 0 still holds reset values
      @(negedge clock);
      check_reset_values();
      check_outputs();
      finish_test("reset");
   endtask

   task automatic test_default_blink();
      test_base = error_count;
      check_pattern_window(PERSONA_BLINK, 64);
      finish_test("default blink");
   endtask

   task automatic test_swap_alternate();
      int   len;
      logic tap_now;
      test_base = error_count;
      drive_load(PERSONA_ALTERNATE);
      wait_freeze_end(1'b1, len);
      compare_value("freeze_length", 32'(FREEZE_CYCLES), 32'(len));
      compare_value("status", 32'(STATUS_DONE), 32'(status));
      check_pattern_window(PERSONA_ALTERNATE, 24);
      // opposite phase on the pair, taken from the tap bit two cycles back
      repeat (16)
      begin
         step();
         tap_now = m_count_d2[TAP];
         compare_value("led_two_on", 32'(tap_now), 32'(led_two_on));
         compare_value("led_three_on", 32'(!tap_now), 32'(led_three_on));
      end
      finish_test("swap to alternate");
   endtask

   task automatic test_swap_binary_dark();
      int len;
      test_base = error_count;
      drive_load(PERSONA_BINARY);
      wait_freeze_end(1'b1, len);
      compare_value("freeze_length", 32'(FREEZE_CYCLES), 32'(len));
      compare_value("status", 32'(STATUS_DONE), 32'(status));
      check_pattern_window(PERSONA_BINARY, 32);
      drive_load(PERSONA_DARK);
      wait_freeze_end(1'b1, len);
      compare_value("freeze_length", 32'(FREEZE_CYCLES), 32'(len));
      compare_value("status", 32'(STATUS_DONE), 32'(status));
      check_pattern_window(PERSONA_DARK, 32);
      finish_test("swap to binary and dark");
   endtask

   task automatic test_load_during_swap();
      int len;
      int early;
      test_base = error_count;
      early     = 0;
      drive_load(PERSONA_BINARY);
      repeat (2)
      begin
         step();
         early += int'(freeze);
      end
      // second request lands in the middle of the window
      drive_load(PERSONA_DARK);
      early += int'(freeze);
      wait_freeze_end(1'b0, len);
      compare_value("freeze_length", 32'(FREEZE_CYCLES), 32'(early + len));
      compare_value("status", 32'(STATUS_ERROR), 32'(status));
      // first request wins
      check_pattern_window(PERSONA_BINARY, 24);
      compare_value("status", 32'(STATUS_ERROR), 32'(status));
      finish_test("load during swap");
   endtask

   task automatic test_random_swaps();
      logic [31:0] rand_word;
      persona_t    pick;
      int          gap;
      int          i;
      int          accepted_base;
      int          rejected_base;
      test_base     = error_count;
      accepted_base = m_accepted;
      rejected_base = m_rejected;
      for (i = 0; i < RANDOM_LOADS; i++)
      begin
         rand_word = $urandom;
         pick      = persona_t'(rand_word[1:0]);
         rand_word = $urandom;
         // short gaps fall inside a running swap
         gap       = 1 + int'(rand_word % MAX_GAP);
         drive_load(pick);
         repeat (gap) step();
      end
      repeat (FREEZE_CYCLES + 8) step();
      $display("[info] random swaps: %0d accepted, %0d rejected",
               m_accepted - accepted_base, m_rejected - rejected_base);
      finish_test("random swaps");
   endtask

   ////////////////////
   // timeout
   ////////////////////

   initial
   begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge clock);
         cycle_count++;
      end
      $display("timeout: no verdict after %0d clock cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

   ////////////////////
   // main sequence
   ////////////////////

   initial
   begin
      rst          <= 1'b1;
      load         <= 1'b0;
      persona_sel  <= PERSONA_BLINK;
      error_count  = 0;
      test_base    = 0;
      tests_run    = 0;
      tests_failed = 0;
      seed_word    = $urandom(SEED);
      test_reset();
      test_default_blink();
      test_swap_alternate();
      test_swap_binary_dark();
      test_load_during_swap();
      test_random_swaps();
      $display("[summary] %0d tests, %0d failed, %0d mismatches",
               tests_run, tests_failed, error_count);
      if (error_count == 0)
      begin
         $display("Simulation finished: PASS");
      end
      else
      begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule
